/* src/cnn_types_pkg.sv */
// scalar widths, kernel constants and enums shared by every block of the conv slice
// import inside a module body wherever these types are needed
package cnn_types_pkg;

    localparam int DATA_W = 8;
    localparam int ACC_W  = 24;
    localparam int ADDR_W = 8;
    localparam int TAPS   = 25;   // 5x5 kernel
    localparam int TAP_W  = 5;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef logic [ADDR_W-1:0]        addr_t;
    typedef logic [TAP_W-1:0]         tap_t;

    // same encoding as the nth_conv selector of the weight buffer
    typedef enum logic [1:0] {
        LAYER_1 = 2'b00,
        LAYER_2 = 2'b01
    } layer_e;

    typedef enum logic [1:0] {
        WB_IDLE    = 2'd0,
        WB_L1_RUN  = 2'd1,
        WB_L2_RUN  = 2'd2,
        WB_L2_WAIT = 2'd3
    } wbuf_state_e;

    typedef enum logic [1:0] {
        SQ_IDLE = 2'd0,
        SQ_RUN  = 2'd1,
        SQ_DONE = 2'd2
    } seq_state_e;

endpackage

/* src/cnn_bus_pkg.sv */
// packed write strobes and the tap beat passed between blocks
package cnn_bus_pkg;

    // one weight word into one bank
    typedef struct packed {
        logic                  en;
        logic [7:0]            bank;
        cnn_types_pkg::addr_t  addr;
        cnn_types_pkg::data_t  data;
    } wmem_wr_t;

    // one activation into the window
    typedef struct packed {
        logic                  en;
        cnn_types_pkg::tap_t   tap;
        cnn_types_pkg::data_t  data;
    } act_wr_t;

    // travels alongside the registered weights
    typedef struct packed {
        logic                  valid;
        cnn_types_pkg::tap_t   tap;
        logic                  last;   // final tap of the kernel
    } tap_beat_t;

endpackage

/* src/weight_mem.sv */
// banked kernel weight store, one bank per output lane, written by bank index
module weight_mem #(
    parameter int BAND_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cnn_bus_pkg::wmem_wr_t     wr_i,
    input  logic                      rd_en_i   [BAND_WIDTH],
    input  cnn_types_pkg::addr_t      rd_addr_i [BAND_WIDTH],
    output cnn_types_pkg::data_t      rd_data_o [BAND_WIDTH]
);
    import cnn_types_pkg::*;

    localparam int DEPTH = 2 ** ADDR_W;

    for (genvar b = 0; b < BAND_WIDTH; b++) begin : g_bank
        data_t mem_q [DEPTH];
        data_t rd_q;

        always_ff @(posedge clk) begin
            if (wr_i.en && wr_i.bank == 8'(b)) begin
                mem_q[wr_i.addr] <= wr_i.data;
            end
        end

        // output holds its last word while the lane is idle
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                rd_q <= '0;
            end else if (rd_en_i[b]) begin
                rd_q <= mem_q[rd_addr_i[b]];
            end
        end

        assign rd_data_o[b] = rd_q;
    end

endmodule

/* src/weight_buffer.sv */
// walks the 25 kernel taps per pass, drives bank addresses and lane enables,
// and hands registered weights plus a tap beat to the MAC array
module weight_buffer #(
    parameter int BAND_WIDTH  = 8,
    parameter int L1_CHANNELS = 6
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      weight_start_i,
    input  cnn_types_pkg::layer_e     layer_i,
    input  logic                      burst_last_i,
    input  logic                      conv_done_i,
    output cnn_types_pkg::addr_t      w_addr_o   [BAND_WIDTH],
    output logic                      w_enable_o [BAND_WIDTH],
    input  cnn_types_pkg::data_t      w_data_i   [BAND_WIDTH],
    output cnn_types_pkg::data_t      w_data_o   [BAND_WIDTH],
    output logic                      lane_en_o  [BAND_WIDTH],
    output cnn_bus_pkg::tap_beat_t    beat_o
);
    import cnn_types_pkg::*;
    import cnn_bus_pkg::*;

    wbuf_state_e state_q, state_d;
    tap_t        tap_q, tap_d;
    logic [3:0]  group_q, group_d;
    logic        run;
    addr_t       addr_c;
    logic        en_c    [BAND_WIDTH];
    logic        en_s1_q [BAND_WIDTH];
    logic        en_s2_q [BAND_WIDTH];
    tap_beat_t   beat_c, beat_s1_q, beat_s2_q;
    data_t       w_data_q [BAND_WIDTH];

    always_comb begin
        state_d = state_q;
        tap_d   = tap_q;
        group_d = group_q;
        case (state_q)
            WB_IDLE: begin
                if (weight_start_i) begin
                    state_d = (layer_i == LAYER_1) ? WB_L1_RUN : WB_L2_RUN;
                    tap_d   = '0;
                    group_d = 4'd1;   // second layer groups start at offset TAPS
                end
            end
            WB_L1_RUN, WB_L2_RUN: begin
                tap_d = tap_q + tap_t'(1);
                if (tap_q == tap_t'(TAPS - 1)) begin
                    tap_d   = '0;
                    state_d = (state_q == WB_L1_RUN) ? WB_IDLE : WB_L2_WAIT;
                end
            end
            WB_L2_WAIT: begin
                if (conv_done_i) begin
                    state_d = WB_IDLE;
                end else if (burst_last_i) begin
                    state_d = WB_L2_RUN;
                    group_d = group_q + 4'd1;
                end
            end
            default: state_d = WB_IDLE;
        endcase
    end

    assign run    = (state_q == WB_L1_RUN) || (state_q == WB_L2_RUN);
    assign addr_c = (state_q == WB_L2_RUN)
                  ? addr_t'(tap_q) + addr_t'(TAPS) * addr_t'(group_q)
                  : addr_t'(tap_q);
    assign beat_c = '{valid: run, tap: tap_q, last: run && tap_q == tap_t'(TAPS - 1)};

    always_comb begin
        for (int i = 0; i < BAND_WIDTH; i++) begin
            en_c[i]       = run && (state_q == WB_L2_RUN || i < L1_CHANNELS);
            w_addr_o[i]   = addr_c;
            w_enable_o[i] = en_c[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= WB_IDLE;
            tap_q     <= '0;
            group_q   <= 4'd1;
            beat_s1_q <= '0;
            beat_s2_q <= '0;
            for (int i = 0; i < BAND_WIDTH; i++) begin
                en_s1_q[i] <= 1'b0;
                en_s2_q[i] <= 1'b0;
            end
        end else begin
            state_q   <= state_d;
            tap_q     <= tap_d;
            group_q   <= group_d;
            beat_s1_q <= beat_c;      // first stage covers the memory read
            beat_s2_q <= beat_s1_q;
            en_s1_q   <= en_c;
            en_s2_q   <= en_s1_q;
        end
    end

    always_ff @(posedge clk) begin
        w_data_q <= w_data_i;
    end

    assign w_data_o  = w_data_q;
    assign lane_en_o = en_s2_q;
    assign beat_o    = beat_s2_q;

endmodule

/* src/window_mac_array.sv */
// holds the 25-tap activation window and accumulates one dot product per lane
module window_mac_array #(
    parameter int BAND_WIDTH = 8
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cnn_bus_pkg::act_wr_t      act_wr_i,
    input  cnn_types_pkg::data_t      w_data_i  [BAND_WIDTH],
    input  logic                      lane_en_i [BAND_WIDTH],
    input  cnn_bus_pkg::tap_beat_t    beat_i,
    output cnn_types_pkg::acc_t       result_o  [BAND_WIDTH],
    output logic                      result_valid_o
);
    import cnn_types_pkg::*;

    data_t act_q [TAPS];
    acc_t  acc_q [BAND_WIDTH];
    acc_t  acc_d [BAND_WIDTH];
    acc_t  result_q [BAND_WIDTH];
    logic  result_valid_q;

    // the window may be rewritten while result_q still holds the last pass
    always_ff @(posedge clk) begin
        if (act_wr_i.en && act_wr_i.tap < tap_t'(TAPS)) begin
            act_q[act_wr_i.tap] <= act_wr_i.data;
        end
    end

    always_comb begin
        for (int i = 0; i < BAND_WIDTH; i++) begin
            acc_d[i] = acc_t'(w_data_i[i]) * acc_t'(act_q[beat_i.tap]);
            if (beat_i.tap != '0) begin
                acc_d[i] = acc_d[i] + acc_q[i];   // tap 0 starts a fresh sum
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < BAND_WIDTH; i++) begin
            if (beat_i.valid && lane_en_i[i]) begin
                acc_q[i] <= acc_d[i];
            end
            if (beat_i.valid && beat_i.last) begin
                result_q[i] <= lane_en_i[i] ? acc_d[i] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid_q <= 1'b0;
        end else begin
            result_valid_q <= beat_i.valid && beat_i.last;
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = result_valid_q;

endmodule

/* src/conv_seq.sv */
// starts the weight buffer and counts finished groups until the convolution is done
module conv_seq (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start_i,
    input  cnn_types_pkg::layer_e     layer_i,
    input  logic [3:0]                num_groups_i,
    input  logic                      result_valid_i,
    output logic                      weight_start_o,
    output cnn_types_pkg::layer_e     layer_o,
    output logic                      conv_done_o,
    output logic                      busy_o
);
    import cnn_types_pkg::*;

    seq_state_e state_q;
    layer_e     layer_q;
    logic [3:0] groups_q;
    logic [3:0] done_cnt_q;
    logic [3:0] target;
    logic       weight_start_q;

    // the first layer always runs a single pass
    assign target = (layer_q == LAYER_1) ? 4'd1 : groups_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q        <= SQ_IDLE;
            layer_q        <= LAYER_1;
            groups_q       <= '0;
            done_cnt_q     <= '0;
            weight_start_q <= 1'b0;
        end else begin
            weight_start_q <= 1'b0;
            case (state_q)
                SQ_IDLE, SQ_DONE: begin
                    if (start_i) begin
                        state_q        <= SQ_RUN;
                        layer_q        <= layer_i;
                        groups_q       <= num_groups_i;
                        done_cnt_q     <= '0;
                        weight_start_q <= 1'b1;
                    end
                end
                SQ_RUN: begin   // start_i is ignored here
                    if (result_valid_i) begin
                        done_cnt_q <= done_cnt_q + 4'd1;
                        if (done_cnt_q + 4'd1 == target) state_q <= SQ_DONE;
                    end
                end
                default: state_q <= SQ_IDLE;
            endcase
        end
    end

    assign weight_start_o = weight_start_q;
    assign layer_o        = layer_q;
    assign conv_done_o    = (state_q == SQ_DONE);
    assign busy_o         = (state_q == SQ_RUN);

endmodule

/* src/conv_engine_top.sv */
// one convolution slice: sequencer, weight buffer, banked weight memory and MAC array
module conv_engine_top #(
    parameter int BAND_WIDTH  = 8,
    parameter int L1_CHANNELS = 6
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cnn_bus_pkg::wmem_wr_t     wmem_wr_i,
    input  cnn_bus_pkg::act_wr_t      act_wr_i,
    input  logic                      start_i,
    input  cnn_types_pkg::layer_e     layer_i,
    input  logic [3:0]                num_groups_i,
    input  logic                      burst_last_i,   // a new window has been loaded
    output cnn_types_pkg::acc_t       result_o [BAND_WIDTH],
    output logic                      result_valid_o,
    output logic                      busy_o,
    output logic                      conv_done_o
);
    import cnn_types_pkg::*;
    import cnn_bus_pkg::*;

    logic      weight_start;
    layer_e    layer;
    logic      result_valid;
    addr_t     w_addr    [BAND_WIDTH];
    logic      w_enable  [BAND_WIDTH];
    data_t     mem_data  [BAND_WIDTH];
    data_t     w_data    [BAND_WIDTH];
    logic      lane_en   [BAND_WIDTH];
    tap_beat_t beat;

    conv_seq i_conv_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_i        (start_i),
        .layer_i        (layer_i),
        .num_groups_i   (num_groups_i),
        .result_valid_i (result_valid),
        .weight_start_o (weight_start),
        .layer_o        (layer),
        .conv_done_o    (conv_done_o),
        .busy_o         (busy_o)
    );

    weight_buffer #(
        .BAND_WIDTH  (BAND_WIDTH),
        .L1_CHANNELS (L1_CHANNELS)
    ) i_weight_buffer (
        .clk            (clk),
        .rst_n          (rst_n),
        .weight_start_i (weight_start),
        .layer_i        (layer),
        .burst_last_i   (burst_last_i),
        .conv_done_i    (conv_done_o),
        .w_addr_o       (w_addr),
        .w_enable_o     (w_enable),
        .w_data_i       (mem_data),
        .w_data_o       (w_data),
        .lane_en_o      (lane_en),
        .beat_o         (beat)
    );

    weight_mem #(
        .BAND_WIDTH (BAND_WIDTH)
    ) i_weight_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_i      (wmem_wr_i),
        .rd_en_i   (w_enable),
        .rd_addr_i (w_addr),
        .rd_data_o (mem_data)
    );

    window_mac_array #(
        .BAND_WIDTH (BAND_WIDTH)
    ) i_window_mac_array (
        .clk            (clk),
        .rst_n          (rst_n),
        .act_wr_i       (act_wr_i),
        .w_data_i       (w_data),
        .lane_en_i      (lane_en),
        .beat_i         (beat),
        .result_o       (result_o),
        .result_valid_o (result_valid)
    );

    assign result_valid_o = result_valid;

endmodule

/* verification/conv_engine_tb.sv */
// directed testbench for the conv slice that loads weights and windows through the write strobes
// build with the sources from the file list, top module conv_engine_tb
module conv_engine_tb;
    import cnn_types_pkg::*;
    import cnn_bus_pkg::*;

    localparam int BAND_WIDTH  = 8;
    localparam int L1_CHANNELS = 6;
    localparam int RESULT_WAIT = 60;
    // about 1200 weight writes, 150 window writes and 260 cycles of passes, plus margin
    localparam int MAX_CYCLES  = 2000;

    logic       clk;
    logic       rst_n;
    wmem_wr_t   wmem_wr;
    act_wr_t    act_wr;
    logic       start;
    layer_e     layer;
    logic [3:0] num_groups;
    logic       burst_last;
    acc_t       result [BAND_WIDTH];
    logic       result_valid;
    logic       busy;
    logic       conv_done;

    data_t w_model [BAND_WIDTH][256];   // shadow of every bank
    data_t a_model [TAPS];
    int    seed = 47;
    int    errors;
    int    err_base;
    int    tests_ok;
    int    tests_bad;
    int    cycle_cnt;

    conv_engine_top #(
        .BAND_WIDTH  (BAND_WIDTH),
        .L1_CHANNELS (L1_CHANNELS)
    ) i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .wmem_wr_i      (wmem_wr),
        .act_wr_i       (act_wr),
        .start_i        (start),
        .layer_i        (layer),
        .num_groups_i   (num_groups),
        .burst_last_i   (burst_last),
        .result_o       (result),
        .result_valid_o (result_valid),
        .busy_o         (busy),
        .conv_done_o    (conv_done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run stopped after %0d cycles", cycle_cnt);
        $display("Test failed");
        $finish;
    end

    task automatic check_acc(input string name, input acc_t expected, input acc_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b, actual %b", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_cycles(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("Fail %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
            errors++;
        end
    endtask

    function automatic data_t weight_pattern(input int lane, input int addr);
        return data_t'(((lane * 37 + addr * 11) % 61) - 30);
    endfunction

    // dot product of one lane's kernel at the given offset with the window
    function automatic acc_t model_sum(input int lane, input int offset);
        int sum;
        sum = 0;
        for (int t = 0; t < TAPS; t++) begin
            sum += int'(w_model[lane][offset + t]) * int'(a_model[t]);
        end
        return acc_t'(sum);
    endfunction

    // every task below starts and ends one time unit after a rising edge
    task automatic load_weight(input int lane, input int addr, input data_t value);
        wmem_wr.en   = 1'b1;
        wmem_wr.bank = 8'(lane);
        wmem_wr.addr = addr_t'(addr);
        wmem_wr.data = value;
        w_model[lane][addr] = value;
        @(posedge clk);
        #1;
        wmem_wr.en = 1'b0;
    endtask

    task automatic load_window(input int tap, input data_t value);
        act_wr.en   = 1'b1;
        act_wr.tap  = tap_t'(tap);
        act_wr.data = value;
        a_model[tap] = value;
        @(posedge clk);
        #1;
        act_wr.en = 1'b0;
    endtask

    task automatic fill_weights(input int offset, input bit use_random);
        data_t value;
        for (int lane = 0; lane < BAND_WIDTH; lane++) begin
            for (int t = 0; t < TAPS; t++) begin
                value = use_random ? data_t'($random(seed)) : weight_pattern(lane, offset + t);
                load_weight(lane, offset + t, value);
            end
        end
    endtask

    task automatic fill_window(input int salt, input bit use_random);
        data_t value;
        for (int t = 0; t < TAPS; t++) begin
            value = use_random ? data_t'($random(seed)) : data_t'(((t * 13 + salt * 7) % 41) - 20);
            load_window(t, value);
        end
    endtask

    task automatic pulse_start(input layer_e mode, input int groups);
        layer      = mode;
        num_groups = 4'(groups);
        start      = 1'b1;
        @(posedge clk);   // this edge samples start
        #1;
        start = 1'b0;
    endtask

    task automatic pulse_burst();
        burst_last = 1'b1;
        @(posedge clk);
        #1;
        burst_last = 1'b0;
    endtask

    // counts edges until result_valid is seen high after one of them
    task automatic wait_result(input int limit, output int edges, output logic seen);
        edges = 0;
        seen  = 1'b0;
        while (!seen && edges < limit) begin
            @(posedge clk);
            #1;
            edges++;
            if (result_valid) seen = 1'b1;
        end
    endtask

    task automatic expect_result(input string name, input int expected_edges,
                                 input int offset, input int active);
        int   edges;
        logic seen;
        acc_t expected;
        wait_result(RESULT_WAIT, edges, seen);
        if (!seen) begin
            $display("%s: result_valid_o never came within %0d cycles", name, RESULT_WAIT);
            errors++;
        end else begin
            check_cycles(name, expected_edges, edges);
            for (int i = 0; i < BAND_WIDTH; i++) begin
                expected = (i < active) ? model_sum(i, offset) : '0;
                check_acc($sformatf("%s lane %0d", name, i), expected, result[i]);
            end
        end
    endtask

    task automatic begin_test();
        err_base = errors;
    endtask

    task automatic end_test(input string name);
        if (errors == err_base) begin
            $display("%s: ok", name);
            tests_ok++;
        end else begin
            $display("%s: %0d errors", name, errors - err_base);
            tests_bad++;
        end
    endtask

    task automatic test_reset_state();
        begin_test();
        for (int i = 0; i < 10; i++) begin
            check_flag("reset_state result_valid", 1'b0, result_valid);
            check_flag("reset_state conv_done", 1'b0, conv_done);
            check_flag("reset_state busy", 1'b0, busy);
            @(posedge clk);
            #1;
        end
        end_test("reset_state");
    endtask

    task automatic test_l1_dot_product();
        begin_test();
        fill_weights(0, 1'b0);   // lanes 6 and 7 get weights too and must still read zero
        fill_window(0, 1'b0);
        pulse_start(LAYER_1, 0);
        expect_result("l1_dot_product", 28, 0, L1_CHANNELS);
        end_test("l1_dot_product");
    endtask

    task automatic test_l1_timing_done();
        begin_test();
        @(posedge clk);   // the previous run reports done on this edge
        #1;
        pulse_start(LAYER_1, 0);
        check_flag("l1_timing_done busy after start", 1'b1, busy);
        expect_result("l1_timing_done", 28, 0, L1_CHANNELS);
        check_flag("l1_timing_done done with result", 1'b0, conv_done);
        @(posedge clk);
        #1;
        check_flag("l1_timing_done conv_done", 1'b1, conv_done);
        check_flag("l1_timing_done busy", 1'b0, busy);
        end_test("l1_timing_done");
    endtask

    task automatic test_l2_groups();
        begin_test();
        for (int g = 1; g <= 3; g++) begin
            fill_weights(TAPS * g, 1'b0);
        end
        fill_window(1, 1'b0);
        pulse_start(LAYER_2, 3);
        expect_result("l2_groups group 1", 28, TAPS, BAND_WIDTH);
        for (int g = 2; g <= 3; g++) begin
            check_flag("l2_groups done too early", 1'b0, conv_done);
            fill_window(g, 1'b0);
            pulse_burst();
            expect_result($sformatf("l2_groups group %0d", g), 27, TAPS * g, BAND_WIDTH);
        end
        end_test("l2_groups");
    endtask

    task automatic test_l2_done_stray();
        int   edges;
        logic seen;
        begin_test();
        @(posedge clk);
        #1;
        check_flag("l2_done_stray conv_done", 1'b1, conv_done);
        check_flag("l2_done_stray busy", 1'b0, busy);
        pulse_burst();
        wait_result(40, edges, seen);
        check_flag("l2_done_stray extra result", 1'b0, seen);
        check_flag("l2_done_stray conv_done held", 1'b1, conv_done);
        end_test("l2_done_stray");
    endtask

    task automatic test_random_l2();
        begin_test();
        fill_weights(TAPS, 1'b1);
        fill_weights(2 * TAPS, 1'b1);
        fill_window(0, 1'b1);
        pulse_start(LAYER_2, 2);
        expect_result("random_l2 group 1", 28, TAPS, BAND_WIDTH);
        fill_window(0, 1'b1);
        pulse_burst();
        expect_result("random_l2 group 2", 27, 2 * TAPS, BAND_WIDTH);
        @(posedge clk);
        #1;
        check_flag("random_l2 conv_done", 1'b1, conv_done);
        end_test("random_l2");
    endtask

    initial begin
        rst_n      = 1'b0;
        wmem_wr    = '0;
        act_wr     = '0;
        start      = 1'b0;
        layer      = LAYER_1;
        num_groups = '0;
        burst_last = 1'b0;
        errors     = 0;
        err_base   = 0;
        tests_ok   = 0;
        tests_bad  = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_l1_dot_product();
        test_l1_timing_done();
        test_l2_groups();
        test_l2_done_stray();
        test_random_l2();

        $display("summary: %0d tests clean, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* conv_engine_top.f */
src/cnn_types_pkg.sv
src/cnn_bus_pkg.sv
src/weight_mem.sv
src/weight_buffer.sv
src/window_mac_array.sv
src/conv_seq.sv
src/conv_engine_top.sv
verification/conv_engine_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the conv slice testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module conv_engine_tb \
    -f conv_engine_top.f \
    --Mdir obj_dir -o conv_engine_sim

output=$(./obj_dir/conv_engine_sim)
echo "$output"

echo "$output" | grep -qx "Test passed"
